// File: list.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/cpuTop.sv
dv/cpuChecker.sv
dv/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuTb;

  import isaPkg::*;
  import pipePkg::*;

  localparam int NUM_TESTS   = 12;
  localparam int PROG_WORDS  = 64;
  localparam int CLK_PERIOD  = 100;
  localparam int TEST_CYCLES = 16 + 3 * PROG_WORDS + 20;  // Watchdog budget per test
  localparam int HALT_WAIT   = 3 * PROG_WORDS + 4;        // Worst case, every branch taken

  logic                       clk;
  logic                       reset;
  logic [`DATA_WIDTH-1:0]     instr, instrAddr, regWriteData;
  logic                       hlt, regWriteEn;
  logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
  logic [`DATA_WIDTH-1:0]     prog [PROG_WORDS];
  logic [31:0]                lcgState = 32'h5d92_aa52;

  cpuTop dut_i (
    .clk, .reset, .instr, .instrAddr, .hlt, .regWriteEn, .regWriteAddr, .regWriteData
  );

  cpuChecker chk (
    .clk, .reset, .instrAddr, .hlt, .regWriteEn, .regWriteAddr, .regWriteData
  );

  // Instruction memory, read in the same cycle
  assign instr = (instrAddr < 16'(PROG_WORDS)) ? prog[instrAddr[5:0]] : {OP_HLT, 12'h000};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with tests still running",
             NUM_TESTS * TEST_CYCLES);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic string kindName(input int kind);
    case (kind)
      0:       return "alu";
      1:       return "llb and r0";
      2:       return "dependences";
      default: return "branches";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Program generation
  ////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] genInstr(input int kind, input int addr);
    logic [31:0] r, s;
    logic [3:0]  pick, rd, rs, rt;
    int          maxOff;
    r    = nextRand();
    s    = nextRand();
    pick = r[31:28];
    rd   = (kind == 2) ? {2'b00, r[25:24]} : r[27:24];  // Small pool, dense hazards
    rs   = (kind == 2) ? {2'b00, r[21:20]} : r[23:20];
    rt   = (kind == 2) ? {2'b00, r[17:16]} : r[19:16];
    if (addr < 6) return {OP_LLB, 4'(addr + 1), s[31:24]};  // Seed some registers
    if (pick == 4'd15) return {4'd9, r[27:16]};              // Unknown opcode
    if (kind == 3 && pick < 4'd6) begin
      maxOff = PROG_WORDS - 2 - addr;                        // Forward, stays in program
      if (maxOff > 255) maxOff = 255;
      return {OP_B, s[23:21], 9'(int'(s[20:13]) % (maxOff + 1))};
    end
    if ((kind == 1 && pick < 4'd8) || pick >= 4'd13) return {OP_LLB, rd, s[31:24]};
    return {4'(pick % 4'd7), rd, rs, rt};                    // ADD through SRA
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reference model, one instruction at a time
  ////////////////////////////////////////////////////////////////////
  task automatic runModel(output logic [15:0] haltPc);
    logic [15:0] regs [16];
    flagsT       f;
    logic [15:0] pc, w, a, b, res;
    logic        wr, taken;
    opcodeT      op;
    int          exact;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    f      = '0;
    pc     = '0;
    haltPc = '0;
    while (pc < 16'(PROG_WORDS)) begin
      w  = prog[pc[5:0]];
      op = opcodeT'(w[15:12]);
      a  = regs[w[7:4]];
      b  = regs[w[3:0]];
      wr = 1'b1;
      res = '0;
      if (op == OP_HLT) begin
        haltPc = pc;
        break;
      end
      pc = pc + 16'd1;
      case (op)
        OP_ADD, OP_SUB: begin
          res = (op == OP_ADD) ? a + b : a - b;
          exact = (op == OP_ADD) ? int'($signed(a)) + int'($signed(b))
                                 : int'($signed(a)) - int'($signed(b));
          f.z = (res == 16'd0);
          f.n = res[15];
          f.v = (exact > 32767) || (exact < -32768);         // Out of signed range
        end
        OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA: begin
          case (op)
            OP_AND:  res = a & b;
            OP_NOR:  res = ~(a | b);
            OP_SLL:  res = a << w[3:0];
            OP_SRL:  res = a >> w[3:0];
            default: res = $signed(a) >>> w[3:0];
          endcase
          f = '{z: (res == 16'd0), n: 1'b0, v: 1'b0};
        end
        OP_LLB: res = {{8{w[7]}}, w[7:0]};
        OP_B: begin
          wr = 1'b0;
          case (condT'(w[11:9]))
            CC_NE:   taken = !f.z;
            CC_EQ:   taken = f.z;
            CC_GT:   taken = !f.z && !f.n;
            CC_LT:   taken = f.n;
            CC_GE:   taken = !f.n;
            CC_LE:   taken = f.z || f.n;
            CC_OV:   taken = f.v;
            default: taken = 1'b1;
          endcase
          if (taken) pc = pc + {{7{w[8]}}, w[8:0]};
        end
        default: wr = 1'b0;  // No-op
      endcase
      if (wr && w[11:8] != 4'd0) begin
        regs[w[11:8]] = res;
        chk.expectWrite(w[11:8], res);
      end
    end
  endtask

  initial begin
    logic [15:0] haltPc;
    int          cycles;
    reset = 1'b1;
    for (int a = 0; a < PROG_WORDS; a++) prog[a] = {OP_HLT, 6'd0, 6'(a)};
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      for (int a = 0; a < PROG_WORDS - 1; a++) prog[a] = genInstr(t % 4, a);
      prog[PROG_WORDS - 1] = {OP_HLT, 12'h000};
      chk.startTest();
      runModel(haltPc);
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      cycles = 0;
      while (hlt !== 1'b1 && cycles < HALT_WAIT) begin
        @(negedge clk);
        cycles++;
      end
      repeat (8) @(negedge clk);  // Stray writes after halt
      chk.endTest(t, kindName(t % 4), haltPc);
    end
    chk.printCounts();
    if (chk.failedTests == 0) $display("All tests passed!");
    else                      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuChecker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`DATA_WIDTH-1:0]     instrAddr,
  input  logic                       hlt,
  input  logic                       regWriteEn,
  input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
  input  logic [`DATA_WIDTH-1:0]     regWriteData
);

  logic [`REG_ADDR_WIDTH-1:0] expAddr [$];  // Model writes, program order
  logic [`DATA_WIDTH-1:0]     expData [$];
  int writeErrors   = 0;                     // Running totals over the whole run
  int writeCount    = 0;
  int errorsAtStart = 0;
  int writesAtStart = 0;
  int passedTests   = 0;
  int failedTests   = 0;

  task automatic expectWrite(input logic [`REG_ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic startTest();
    expAddr.delete();
    expData.delete();
    errorsAtStart = writeErrors;
    writesAtStart = writeCount;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Writeback compare, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!reset && regWriteEn === 1'b1) begin
      writeCount++;
      if (expAddr.size() == 0) begin
        $display("Extra write to R%0d with data 0x%04h after the expected writes ended",
                 regWriteAddr, regWriteData);
        writeErrors++;
      end else begin
        if (regWriteAddr !== expAddr[0]) begin
          $display("CHECK FAILED regWriteAddr expected 0x%0h got 0x%0h",
                   expAddr[0], regWriteAddr);
          writeErrors++;
        end
        if (regWriteData !== expData[0]) begin
          $display("CHECK FAILED regWriteData expected 0x%04h got 0x%04h",
                   expData[0], regWriteData);
          writeErrors++;
        end
        void'(expAddr.pop_front());
        void'(expData.pop_front());
      end
    end
  end

  // Halt state and leftovers, one result line per test
  task automatic endTest(input int num, input string name,
                         input logic [`DATA_WIDTH-1:0] haltPc);
    int errs;
    errs = writeErrors - errorsAtStart;
    if (hlt !== 1'b1) begin
      $display("Test %0d: hlt never rose within the wait limit", num);
      errs++;
    end else if (instrAddr !== haltPc) begin
      $display("CHECK FAILED instrAddr expected 0x%04h got 0x%04h", haltPc, instrAddr);
      errs++;
    end
    if (expAddr.size() != 0) begin
      $display("Test %0d: %0d expected writes never appeared", num, expAddr.size());
      errs++;
    end
    if (errs == 0) passedTests++;
    else           failedTests++;
    $display("Test %0d (%s): %s, %0d writes, %0d errors", num, name,
             (errs == 0) ? "ok" : "FAILED", writeCount - writesAtStart, errs);
  endtask

  task automatic printCounts();
    $display("Tests run %0d, ok %0d, failed %0d", passedTests + failedTests,
             passedTests, failedTests);
  endtask

endmodule

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuTop (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`DATA_WIDTH-1:0]     instr,
  output logic [`DATA_WIDTH-1:0]     instrAddr,
  output logic                       hlt,
  output logic                       regWriteEn,    // Single-cycle pulse per write
  output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
  output logic [`DATA_WIDTH-1:0]     regWriteData
);

  import isaPkg::*;

  // Fetch to decode
  logic                       idValid;
  logic [`DATA_WIDTH-1:0]     idInstr, idPc;

  // Decode to execute
  logic                       exValid;
  opcodeT                     exOp;
  logic [`REG_ADDR_WIDTH-1:0] exRd, exRs, exRt;
  logic [`DATA_WIDTH-1:0]     exRsData, exRtData, exImm, exPc;
  logic [`SHAMT_WIDTH-1:0]    exShamt;
  condT                       exCond;

  // Execute back to fetch, redirect also flushes
  logic                       redirectEn, haltReq;
  logic [`DATA_WIDTH-1:0]     redirectPc;

  ////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////
  fetchStage fetchU (
    .clk, .reset, .redirectEn, .redirectPc, .haltReq, .instr,
    .instrAddr, .idValid, .idInstr, .idPc, .hlt
  );

  decodeStage decodeU (
    .clk, .reset, .idValid, .idInstr, .idPc,
    .flush  (redirectEn),
    .wbEn   (regWriteEn),     // Writeback exposed at the top
    .wbAddr (regWriteAddr),
    .wbData (regWriteData),
    .exValid, .exOp, .exRd, .exRs, .exRt, .exRsData, .exRtData,
    .exImm, .exShamt, .exCond, .exPc
  );

  executeStage executeU (
    .clk, .reset, .exValid, .exOp, .exRd, .exRs, .exRt,
    .exRsData, .exRtData, .exImm, .exShamt, .exCond, .exPc,
    .redirectEn, .redirectPc, .haltReq,
    .wbEn   (regWriteEn),
    .wbAddr (regWriteAddr),
    .wbData (regWriteData)
  );

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module executeStage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       exValid,
  input  isaPkg::opcodeT             exOp,
  input  logic [`REG_ADDR_WIDTH-1:0] exRd,
  input  logic [`REG_ADDR_WIDTH-1:0] exRs,
  input  logic [`REG_ADDR_WIDTH-1:0] exRt,
  input  logic [`DATA_WIDTH-1:0]     exRsData,
  input  logic [`DATA_WIDTH-1:0]     exRtData,
  input  logic [`DATA_WIDTH-1:0]     exImm,
  input  logic [`SHAMT_WIDTH-1:0]    exShamt,
  input  isaPkg::condT               exCond,
  input  logic [`DATA_WIDTH-1:0]     exPc,
  output logic                       redirectEn,
  output logic [`DATA_WIDTH-1:0]     redirectPc,
  output logic                       haltReq,
  output logic                       wbEn,
  output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
  output logic [`DATA_WIDTH-1:0]     wbData
);

  import isaPkg::*;
  import pipePkg::*;

  fwdSelT                 rsSel, rtSel;
  logic [`DATA_WIDTH-1:0] opA, opB;
  logic [`DATA_WIDTH-1:0] aluOut;
  logic                   setFlags, isArith, writesReg;
  flagsT                  flags, flagsNext;
  logic                   condMet, brTaken;

  ////////////////////////////////////////////////////////////////////
  // Operand forwarding from EX/WB
  ////////////////////////////////////////////////////////////////////
  assign rsSel = (wbEn && wbAddr == exRs) ? FWD_WB : FWD_REG;
  assign rtSel = (wbEn && wbAddr == exRt) ? FWD_WB : FWD_REG;
  assign opA   = (rsSel == FWD_WB) ? wbData : exRsData;
  assign opB   = (rtSel == FWD_WB) ? wbData : exRtData;

  ////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    aluOut    = '0;
    setFlags  = 1'b1;
    isArith   = 1'b0;
    writesReg = 1'b1;
    case (exOp)
      OP_ADD: begin aluOut = opA + opB; isArith = 1'b1; end
      OP_SUB: begin aluOut = opA - opB; isArith = 1'b1; end
      OP_AND: aluOut = opA & opB;
      OP_NOR: aluOut = ~(opA | opB);
      OP_SLL: aluOut = opA << exShamt;
      OP_SRL: aluOut = opA >> exShamt;
      OP_SRA: aluOut = $signed(opA) >>> exShamt;  // Keeps sign bit
      OP_LLB: begin
        aluOut   = exImm;
        setFlags = 1'b0;
      end
      default: begin   // Branch and HLT
        setFlags  = 1'b0;
        writesReg = 1'b0;
      end
    endcase
  end

  // Next flag value
  always_comb begin
    flagsNext   = flags;
    flagsNext.z = (aluOut == '0);
    flagsNext.n = isArith && aluOut[`DATA_WIDTH-1];
    flagsNext.v = 1'b0;
    if (exOp == OP_ADD)  // Same-sign inputs, result sign flips
      flagsNext.v = (opA[`DATA_WIDTH-1] == opB[`DATA_WIDTH-1]) &&
                    (aluOut[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
    else if (exOp == OP_SUB)
      flagsNext.v = (opA[`DATA_WIDTH-1] != opB[`DATA_WIDTH-1]) &&
                    (aluOut[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
  end

  always_ff @(posedge clk) begin
    if (reset)                    flags <= '0;
    else if (exValid && setFlags) flags <= flagsNext;
  end

  ////////////////////////////////////////////////////////////////////
  // Branch resolution and halt
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (exCond)  // Flags of the previous instruction
      CC_NE:   condMet = !flags.z;
      CC_EQ:   condMet = flags.z;
      CC_GT:   condMet = !flags.z && !flags.n;
      CC_LT:   condMet = flags.n;
      CC_GE:   condMet = !flags.n;
      CC_LE:   condMet = flags.z || flags.n;
      CC_OV:   condMet = flags.v;
      default: condMet = 1'b1;  // CC_UN
    endcase
  end

  assign brTaken    = exValid && exOp == OP_B && condMet;
  assign haltReq    = exValid && exOp == OP_HLT;
  assign redirectEn = brTaken || haltReq;
  assign redirectPc = haltReq ? exPc : exPc + `DATA_WIDTH'(1) + exImm;  // HLT spins on itself

  // EX/WB register
  always_ff @(posedge clk) begin
    wbAddr <= exRd;
    wbData <= aluOut;
    if (reset) wbEn <= 1'b0;
    else       wbEn <= exValid && writesReg && exRd != '0;  // R0 never written
  end

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decodeStage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       idValid,
  input  logic [`DATA_WIDTH-1:0]     idInstr,
  input  logic [`DATA_WIDTH-1:0]     idPc,
  input  logic                       flush,
  input  logic                       wbEn,     // Writeback port from execute
  input  logic [`REG_ADDR_WIDTH-1:0] wbAddr,
  input  logic [`DATA_WIDTH-1:0]     wbData,
  output logic                       exValid,
  output isaPkg::opcodeT             exOp,
  output logic [`REG_ADDR_WIDTH-1:0] exRd,
  output logic [`REG_ADDR_WIDTH-1:0] exRs,
  output logic [`REG_ADDR_WIDTH-1:0] exRt,
  output logic [`DATA_WIDTH-1:0]     exRsData,
  output logic [`DATA_WIDTH-1:0]     exRtData,
  output logic [`DATA_WIDTH-1:0]     exImm,
  output logic [`SHAMT_WIDTH-1:0]    exShamt,
  output isaPkg::condT               exCond,
  output logic [`DATA_WIDTH-1:0]     exPc
);

  import isaPkg::*;

  logic [`DATA_WIDTH-1:0]     regs [`NUM_REGS];
  opcodeT                     op;
  logic                       opKnown;
  logic [`REG_ADDR_WIDTH-1:0] rsAddr, rtAddr;
  logic [`DATA_WIDTH-1:0]     rsData, rtData;
  logic [`DATA_WIDTH-1:0]     imm8Ext, brExt;

  ////////////////////////////////////////////////////////////////////
  // Field split and opcode decode
  ////////////////////////////////////////////////////////////////////
  assign op     = opcodeT'(idInstr[`OPCODE_LSB +: `OPCODE_WIDTH]);
  assign rsAddr = idInstr[`RS_LSB +: `REG_ADDR_WIDTH];
  assign rtAddr = idInstr[`RT_LSB +: `REG_ADDR_WIDTH];

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
      OP_LLB, OP_B, OP_HLT: opKnown = 1'b1;
      default:              opKnown = 1'b0;  // Unknown opcode becomes a bubble
    endcase
  end

  // Sign extension of both immediates
  assign imm8Ext = {{(`DATA_WIDTH-`IMM8_WIDTH){idInstr[`IMM8_WIDTH-1]}},
                    idInstr[`IMM8_WIDTH-1:0]};
  assign brExt   = {{(`DATA_WIDTH-`BR_OFFSET_WIDTH){idInstr[`BR_OFFSET_WIDTH-1]}},
                    idInstr[`BR_OFFSET_WIDTH-1:0]};

  ////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
    end else if (wbEn && wbAddr != '0) begin
      regs[wbAddr] <= wbData;
    end
  end

  // Read port with write-through, R0 hardwired to zero
  function automatic logic [`DATA_WIDTH-1:0] readPort(input logic [`REG_ADDR_WIDTH-1:0] addr);
    logic [`DATA_WIDTH-1:0] val;
    val = regs[addr];
    if (wbEn && wbAddr == addr) val = wbData;  // Distance-two dependence
    if (addr == '0) val = '0;
    return val;
  endfunction

  always_comb begin
    rsData = readPort(rsAddr);
    rtData = readPort(rtAddr);
  end

  ////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    exOp     <= op;
    exRd     <= idInstr[`RD_LSB +: `REG_ADDR_WIDTH];
    exRs     <= rsAddr;
    exRt     <= rtAddr;
    exRsData <= rsData;
    exRtData <= rtData;
    exImm    <= (op == OP_B) ? brExt : imm8Ext;    // One immediate slot
    exShamt  <= idInstr[`RT_LSB +: `SHAMT_WIDTH];
    exCond   <= condT'(idInstr[`COND_LSB +: `COND_WIDTH]);
    exPc     <= idPc;
    if (reset) exValid <= 1'b0;
    else       exValid <= idValid && opKnown && !flush;
  end

endmodule

`default_nettype wire

// File: verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module fetchStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   redirectEn,  // Taken branch or HLT, doubles as flush
  input  logic [`DATA_WIDTH-1:0] redirectPc,
  input  logic                   haltReq,
  input  logic [`DATA_WIDTH-1:0] instr,       // Returned in the same cycle
  output logic [`DATA_WIDTH-1:0] instrAddr,
  output logic                   idValid,
  output logic [`DATA_WIDTH-1:0] idInstr,
  output logic [`DATA_WIDTH-1:0] idPc,
  output logic                   hlt
);

  logic [`DATA_WIDTH-1:0] pc;

  assign instrAddr = pc;

  // PC and halt flag
  always_ff @(posedge clk) begin
    if (reset) begin
      pc  <= '0;
      hlt <= 1'b0;
    end else begin
      if (hlt) begin
        pc <= pc;                         // Frozen until reset
      end else if (redirectEn) begin
        pc <= redirectPc;                 // HLT sends its own address here
      end else begin
        pc <= pc + `DATA_WIDTH'(1);
      end
      hlt <= hlt | haltReq;               // Sticky
    end
  end

  // IF/ID register
  always_ff @(posedge clk) begin
    idInstr <= instr;
    idPc    <= pc;
    if (reset) idValid <= 1'b0;
    else       idValid <= !redirectEn && !hlt;  // Kill the younger slot
  end

endmodule

`default_nettype wire

// File: verilog/pipePkg.sv
`default_nettype none

package pipePkg;

  // Operand source in execute
  typedef enum logic {
    FWD_REG,  // Value read in decode
    FWD_WB    // Value in the EX/WB register
  } fwdSelT;

  // Flag register layout
  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

endpackage

`default_nettype wire

// File: verilog/isaPkg.sv
`default_nettype none

`include "cpu_macros.svh"

package isaPkg;

  // Opcode field, bits 15:12
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OP_ADD = 4'd0,   // Sets Z N V
    OP_SUB = 4'd1,
    OP_AND = 4'd2,   // Logic and shifts set Z only
    OP_NOR = 4'd3,
    OP_SLL = 4'd4,
    OP_SRL = 4'd5,
    OP_SRA = 4'd6,
    OP_LLB = 4'd10,  // Sign-extended imm8
    OP_B   = 4'd12,  // Conditional branch
    OP_HLT = 4'd15
  } opcodeT;

  // Branch condition codes, bits 11:9
  typedef enum logic [`COND_WIDTH-1:0] {
    CC_NE = 3'd0,
    CC_EQ = 3'd1,
    CC_GT = 3'd2,
    CC_LT = 3'd3,
    CC_GE = 3'd4,
    CC_LE = 3'd5,
    CC_OV = 3'd6,
    CC_UN = 3'd7  // Always taken
  } condT;

endpackage

`default_nettype wire

// File: verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and register file sizes
`define DATA_WIDTH      16  // Data words and pc
`define REG_ADDR_WIDTH  4
`define NUM_REGS        16

// Instruction field widths
`define OPCODE_WIDTH    4
`define IMM8_WIDTH      8   // LLB immediate
`define BR_OFFSET_WIDTH 9   // Signed branch offset
`define SHAMT_WIDTH     4
`define COND_WIDTH      3

// Instruction field positions, low bit of each field
`define OPCODE_LSB      12
`define RD_LSB          8
`define RS_LSB          4
`define RT_LSB          0   // Also shift amount, imm8 and offset base
`define COND_LSB        9

`endif
